//--- busMaster.f
busMasterPkg.sv
transferSequencer.sv
arbiterLink.sv
frameShifter.sv
busMaster.sv
busMasterTb.sv

//--- Makefile
TOP = busMasterTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f busMaster.f --top-module $(TOP) -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

//--- busMasterTb.sv
`default_nettype none

module busMasterTb;
    import busMasterPkg::*;

    localparam int DATA_WIDTH  = 8;
    localparam logic [SLAVE_ID_W-1:0] SLAVE_ID = 3'b100;
    localparam int HOLD_CYCLES = 5;
    localparam int WAIT_LIMIT  = 200;   // cycles per wait loop

    logic                  clk = 1'b0;
    logic                  rstN;
    logic                  start;
    logic                  eoc;
    logic                  doneCom;
    logic [DATA_WIDTH-1:0] dataOut;
    logic                  rD;
    logic                  ready;
    logic                  control;
    logic                  wrD;
    logic                  valid;
    logic                  arbCont;
    logic                  arbSend;

    int                    errorCount    = 0;
    int                    checkCount    = 0;
    logic [DATA_WIDTH-1:0] nextWrite;           // payload the next write must carry
    bit                    timedOut      = 1'b0;
    bit                    overlapSeen   = 1'b0;
    bit                    doneDropSeen  = 1'b0;
    bit                    busyAfterDone = 1'b0;

    busMaster #(
        .DATA_WIDTH  (DATA_WIDTH),
        .SLAVE_ID    (SLAVE_ID),
        .HOLD_CYCLES (HOLD_CYCLES)
    ) DUT (
        .clk     (clk),
        .rstN    (rstN),
        .start   (start),
        .eoc     (eoc),
        .doneCom (doneCom),
        .dataOut (dataOut),
        .rD      (rD),
        .ready   (ready),
        .control (control),
        .wrD     (wrD),
        .valid   (valid),
        .arbCont (arbCont),
        .arbSend (arbSend)
    );

    always #5 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // bus rules watched on every cycle
    //////////////////////////////////////////////////////////////////////

    noDataDuringControl: assert property (
        @(posedge clk) disable iff (!rstN) valid |-> !control
    ) else begin
        $display("CHECK FAILED at %0t: valid high together with control", $time);
        overlapSeen = 1'b1;
    end

    doneComHeld: assert property (
        @(posedge clk) disable iff (!rstN) $past(doneCom) |-> doneCom
    ) else begin
        $display("CHECK FAILED at %0t: doneCom fell without reset", $time);
        doneDropSeen = 1'b1;
    end

    quietAfterDone: assert property (
        @(posedge clk) disable iff (!rstN) doneCom |-> (!arbSend && !valid && !control)
    ) else begin
        $display("CHECK FAILED at %0t: bus activity after doneCom", $time);
        busyAfterDone = 1'b1;
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    task automatic nextCycle();
        @(posedge clk);
        #1;   // drive and sample away from the edge
    endtask

    task automatic checkTrue(input logic cond, input string msg);
        checkCount++;
        assert (cond === 1'b1) else begin
            $display("CHECK FAILED at %0t: %s", $time, msg);
            errorCount++;
        end
    endtask

    task automatic stopOnTimeout(input string what);
        $display("timeout at %0t: no %s within %0d cycles", $time, what, WAIT_LIMIT);
        timedOut = 1'b1;
        forever @(posedge clk);   // watcher below ends the run
    endtask

    task automatic reportTest(input string name, input int errBefore);
        $display("test %-22s %0d check(s) failed", name, errorCount - errBefore);
    endtask

    task automatic applyReset(input logic startLevel);
        rstN    = 1'b0;
        start   = startLevel;
        eoc     = 1'b0;
        arbCont = 1'b0;
        ready   = 1'b0;
        rD      = 1'b0;
        repeat (10) begin
            nextCycle();
            checkTrue(!arbSend && !control && !valid && !doneCom, "outputs low in reset");
        end
        rstN = 1'b1;
        checkTrue(!wrD && dataOut == '0, "wrD and dataOut low after reset");
    endtask

    // plays arbiter and slave for one transaction of the expected phase
    task automatic runTransaction(input logic isRead, input logic raiseEoc);
        logic [REQ_LEN-1:0]     reqWord;
        logic [CONTROL_LEN-1:0] frame;
        logic [DATA_WIDTH-1:0]  rdVal;
        logic [DATA_WIDTH-1:0]  wrVal;
        int                     n;
        int                     gap;

        arbCont = 1'b1;   // bus busy
        gap = HOLD_CYCLES + 5 + int'($urandom % 4);   // outlasts the hold, link already waiting
        repeat (gap) begin
            nextCycle();
            checkTrue(!arbSend, "no request while bus busy");
        end
        arbCont = 1'b0;
        n = 0;
        while (arbSend !== 1'b1 && n < WAIT_LIMIT) begin
            nextCycle();
            n++;
        end
        if (arbSend !== 1'b1) stopOnTimeout("bus request");
        for (int i = REQ_LEN - 1; i >= 0; i--) begin
            reqWord[i] = arbSend;
            if (i > 0) nextCycle();
        end
        checkTrue(reqWord == {START_PATTERN, SLAVE_ID},
            $sformatf("request word %b", reqWord));
        if (raiseEoc) eoc = 1'b1;

        // random grant delay then ack 1 0 1
        gap = int'($urandom % 5);
        repeat (gap) begin
            nextCycle();
            checkTrue(!arbSend, "arbSend low while waiting for grant");
        end
        arbCont = 1'b1;
        n = 0;
        while (arbSend !== 1'b1 && n < WAIT_LIMIT) begin
            nextCycle();
            n++;
        end
        if (arbSend !== 1'b1) stopOnTimeout("grant acknowledge");
        nextCycle();
        checkTrue(!arbSend, "ack middle bit 0");
        nextCycle();
        checkTrue(arbSend, "ack last bit 1");

        n = 0;
        while (control !== 1'b1 && n < WAIT_LIMIT) begin
            nextCycle();
            n++;
        end
        if (control !== 1'b1) stopOnTimeout("control frame");
        for (int i = CONTROL_LEN - 1; i >= 0; i--) begin
            frame[i] = control;
            checkTrue(!valid && arbSend, "valid low and bus held during frame");
            if (i > 0) nextCycle();
        end
        checkTrue(frame == {START_PATTERN, SLAVE_ID, isRead},
            $sformatf("control frame %b, read expected %b", frame, isRead));

        if (isRead) begin
            rdVal = DATA_WIDTH'($urandom);
            for (int i = DATA_WIDTH - 1; i >= 0; i--) begin
                gap   = int'($urandom % 3);   // slave stalls a little
                ready = 1'b0;
                repeat (gap) begin
                    rD = 1'($urandom);
                    nextCycle();
                end
                ready = 1'b1;
                rD    = rdVal[i];
                nextCycle();
            end
            ready = 1'b0;
            rD    = 1'b0;
        end else begin
            n = 0;
            while (valid !== 1'b1 && n < WAIT_LIMIT) begin
                nextCycle();
                n++;
            end
            if (valid !== 1'b1) stopOnTimeout("write data");
            for (int i = DATA_WIDTH - 1; i >= 0; i--) begin
                checkTrue(valid, "valid stays high for the whole byte");
                wrVal[i] = wrD;
                nextCycle();
            end
            checkTrue(!valid, "valid drops after DATA_WIDTH bits");
            checkTrue(wrVal == nextWrite,
                $sformatf("written byte %h, expected %h", wrVal, nextWrite));
        end

        //////////////////////////////////////////////////////////////////
        // release 0 1 1 0
        n = 0;
        while (arbSend !== 1'b0 && n < WAIT_LIMIT) begin
            nextCycle();
            n++;
        end
        if (arbSend !== 1'b0) stopOnTimeout("bus release");
        nextCycle();
        checkTrue(arbSend, "release second bit 1");
        nextCycle();
        checkTrue(arbSend, "release third bit 1");
        nextCycle();
        checkTrue(!arbSend, "release ends low");
        if (isRead) begin
            nextCycle();
            checkTrue(dataOut == rdVal,
                $sformatf("dataOut %h, expected %h", dataOut, rdVal));
            nextWrite = rdVal + 1'b1;   // wraps
        end
    endtask

    initial begin : timeoutWatch
        wait (timedOut);
        $display("*** FAILED ***");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin : mainFlow
        int errBefore;
        int n;
        int assertFails;

        rstN      = 1'b1;
        start     = 1'b0;
        eoc       = 1'b0;
        rD        = 1'b0;
        ready     = 1'b0;
        arbCont   = 1'b0;
        nextWrite = '0;
        void'($urandom(32'habfd_6e1b));

        errBefore = errorCount;
        applyReset(1'b0);
        reportTest("reset values", errBefore);

        errBefore = errorCount;
        for (int t = 0; t < 4; t++) begin
            runTransaction(t % 2 == 0, 1'b0);   // read first
        end
        reportTest("start low, read first", errBefore);

        errBefore = errorCount;
        applyReset(1'b1);
        nextWrite = '0;
        for (int t = 0; t < 4; t++) begin
            runTransaction(t % 2 == 1, 1'b0);   // write of 0 first
        end
        reportTest("start high, write first", errBefore);

        errBefore = errorCount;
        runTransaction(1'b0, 1'b1);
        arbCont = 1'b0;   // bus free so a stray request would show
        n = 0;
        while (doneCom !== 1'b1 && n < WAIT_LIMIT) begin
            nextCycle();
            n++;
        end
        if (doneCom !== 1'b1) stopOnTimeout("doneCom after eoc");
        repeat (30) begin
            nextCycle();
            checkTrue(doneCom && !arbSend, "doneCom held and no request after eoc");
        end
        reportTest("end of communication", errBefore);

        assertFails = int'(overlapSeen) + int'(doneDropSeen) + int'(busyAfterDone);
        $display("checks run %0d, failed %0d, concurrent assertions failed %0d",
            checkCount, errorCount, assertFails);
        if (errorCount == 0 && assertFails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- busMaster.sv
`default_nettype none

module busMaster #(
    parameter int DATA_WIDTH  = 8,
    parameter logic [busMasterPkg::SLAVE_ID_W-1:0] SLAVE_ID = 3'b100,
    parameter int HOLD_CYCLES = 5
) (
    input  wire logic                   clk,
    input  wire logic                   rstN,

    //////////////////////////////////////////////////////////////////////
    // host side
    input  wire logic                   start,     // loop begins with a write
    input  wire logic                   eoc,
    output logic                        doneCom,
    output logic [DATA_WIDTH-1:0]       dataOut,

    //////////////////////////////////////////////////////////////////////
    // slave side
    input  wire logic                   rD,
    input  wire logic                   ready,
    output logic                        control,
    output logic                        wrD,
    output logic                        valid,

    //////////////////////////////////////////////////////////////////////
    // arbiter side
    input  wire logic                   arbCont,
    output logic                        arbSend
);
    import busMasterPkg::*;

    busCmd_t     cmdReq;
    busCmd_t     cmdGranted;    // same command once the bus is owned
    xferResult_t shiftResult;
    xferResult_t xferDone;

    transferSequencer #(
        .DATA_WIDTH  (DATA_WIDTH),
        .HOLD_CYCLES (HOLD_CYCLES)
    ) sequencer (
        .clk      (clk),
        .rstN     (rstN),
        .start    (start),
        .eoc      (eoc),
        .xferDone (xferDone),
        .cmdReq   (cmdReq),
        .dataOut  (dataOut),
        .doneCom  (doneCom)
    );

    arbiterLink #(
        .SLAVE_ID (SLAVE_ID)
    ) link (
        .clk         (clk),
        .rstN        (rstN),
        .cmdReq      (cmdReq),
        .shiftResult (shiftResult),
        .arbCont     (arbCont),
        .arbSend     (arbSend),
        .cmdGranted  (cmdGranted),
        .xferDone    (xferDone)
    );

    frameShifter #(
        .DATA_WIDTH (DATA_WIDTH),
        .SLAVE_ID   (SLAVE_ID)
    ) shifter (
        .clk         (clk),
        .rstN        (rstN),
        .cmdGranted  (cmdGranted),
        .rD          (rD),
        .ready       (ready),
        .control     (control),
        .wrD         (wrD),
        .valid       (valid),
        .shiftResult (shiftResult)
    );

endmodule

`default_nettype wire

//--- frameShifter.sv
`default_nettype none

module frameShifter #(
    parameter int DATA_WIDTH = 8,
    parameter logic [busMasterPkg::SLAVE_ID_W-1:0] SLAVE_ID = 3'b100
) (
    input  wire logic                   clk,
    input  wire logic                   rstN,
    input  wire busMasterPkg::busCmd_t  cmdGranted,
    input  wire logic                   rD,
    input  wire logic                   ready,
    output logic                        control,
    output logic                        wrD,
    output logic                        valid,
    output busMasterPkg::xferResult_t   shiftResult
);
    import busMasterPkg::*;

    typedef enum logic [2:0] {
        fIdle,
        fFrame,
        fRead,
        fWrite,
        fWriteEnd
    } shiftState_t;

    localparam int MAX_LEN = (DATA_WIDTH > CONTROL_LEN) ? DATA_WIDTH : CONTROL_LEN;
    localparam int CNT_W   = $clog2(MAX_LEN);

    shiftState_t            state;
    logic [CNT_W-1:0]       bitCnt;
    logic [CONTROL_LEN-1:0] frameWord;
    logic [CONTROL_LEN-1:0] frameShift;
    logic [DATA_WIDTH-1:0]  dataShift;   // write payload or read assembly
    logic                   isRead;

    assign frameWord = {START_PATTERN, SLAVE_ID, cmdGranted.rw};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state       <= fIdle;
            bitCnt      <= '0;
            frameShift  <= '0;
            dataShift   <= '0;
            isRead      <= 1'b0;
            control     <= 1'b0;
            wrD         <= 1'b0;
            valid       <= 1'b0;
            shiftResult <= '0;
        end else begin
            shiftResult.done <= 1'b0;
            case (state)
                fIdle: begin
                    if (cmdGranted.go) begin
                        control    <= frameWord[CONTROL_LEN-1];   // first frame bit
                        frameShift <= frameWord << 1;
                        dataShift  <= cmdGranted.wrByte;
                        isRead     <= cmdGranted.rw;
                        bitCnt     <= CNT_W'(1);
                        state      <= fFrame;
                    end
                end

                //////////////////////////////////////////////////////////////////
                // control frame
                //////////////////////////////////////////////////////////////////
                fFrame: begin
                    control    <= frameShift[CONTROL_LEN-1];
                    frameShift <= frameShift << 1;
                    bitCnt     <= bitCnt + 1'b1;
                    if (bitCnt == CNT_W'(CONTROL_LEN - 1)) begin
                        bitCnt <= '0;
                        state  <= isRead ? fRead : fWrite;
                    end
                end

                //////////////////////////////////////////////////////////////////
                // data byte
                //////////////////////////////////////////////////////////////////
                fRead: begin
                    control <= 1'b0;
                    if (ready) begin   // slave may stall
                        dataShift <= {dataShift[DATA_WIDTH-2:0], rD};
                        bitCnt    <= bitCnt + 1'b1;
                        if (bitCnt == CNT_W'(DATA_WIDTH - 1)) begin
                            shiftResult <= '{done: 1'b1,
                                             rdByte: {dataShift[DATA_WIDTH-2:0], rD}};
                            state       <= fIdle;
                        end
                    end
                end
                fWrite: begin
                    control   <= 1'b0;
                    valid     <= 1'b1;
                    wrD       <= dataShift[DATA_WIDTH-1];   // msb first
                    dataShift <= dataShift << 1;
                    bitCnt    <= bitCnt + 1'b1;
                    if (bitCnt == CNT_W'(DATA_WIDTH - 1)) begin
                        state <= fWriteEnd;
                    end
                end
                fWriteEnd: begin
                    valid            <= 1'b0;
                    wrD              <= 1'b0;
                    shiftResult.done <= 1'b1;
                    state            <= fIdle;
                end
                default: state <= fIdle;
            endcase
        end
    end

    // data and control never share a cycle
    noWriteDuringFrame: assert property (
        @(posedge clk) disable iff (!rstN) (state == fFrame) |-> !valid
    );

endmodule

`default_nettype wire

//--- arbiterLink.sv
`default_nettype none

module arbiterLink #(
    parameter logic [busMasterPkg::SLAVE_ID_W-1:0] SLAVE_ID = 3'b100
) (
    input  wire logic                       clk,
    input  wire logic                       rstN,
    input  wire busMasterPkg::busCmd_t      cmdReq,
    input  wire busMasterPkg::xferResult_t  shiftResult,
    input  wire logic                       arbCont,
    output logic                            arbSend,
    output busMasterPkg::busCmd_t           cmdGranted,
    output busMasterPkg::xferResult_t       xferDone
);
    import busMasterPkg::*;

    typedef enum logic [2:0] {
        lIdle,
        lWaitFree,
        lRequest,
        lWaitGrant,
        lAck,
        lOwned,
        lRelease
    } linkState_t;

    localparam int STEP_W = $clog2(REQ_LEN + 1);

    linkState_t         state;
    logic [STEP_W-1:0]  stepCnt;
    logic [REQ_LEN-1:0] reqShift;
    logic [1:0]         grantSync;   // two-stage arbCont sampler
    busCmd_t            heldCmd;     // kept until the bus is ours

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= lIdle;
            stepCnt    <= '0;
            reqShift   <= '0;
            grantSync  <= '0;
            heldCmd    <= '0;
            arbSend    <= 1'b0;
            cmdGranted <= '0;
            xferDone   <= '0;
        end else begin
            grantSync     <= {grantSync[0], arbCont};
            cmdGranted.go <= 1'b0;
            xferDone.done <= 1'b0;
            case (state)
                lIdle: begin
                    if (cmdReq.go) begin
                        heldCmd <= cmdReq;
                        state   <= lWaitFree;
                    end
                end
                lWaitFree: begin
                    arbSend <= 1'b0;
                    if (!arbCont) begin   // bus free
                        reqShift <= {START_PATTERN, SLAVE_ID};
                        stepCnt  <= '0;
                        state    <= lRequest;
                    end
                end

                //////////////////////////////////////////////////////////////////
                // request and grant
                //////////////////////////////////////////////////////////////////
                lRequest: begin
                    arbSend  <= reqShift[REQ_LEN-1];   // msb first
                    reqShift <= reqShift << 1;
                    stepCnt  <= stepCnt + 1'b1;
                    if (stepCnt == STEP_W'(REQ_LEN - 1)) begin
                        state <= lWaitGrant;
                    end
                end
                lWaitGrant: begin
                    arbSend <= 1'b0;
                    if (grantSync == 2'b11) begin
                        stepCnt <= '0;
                        state   <= lAck;
                    end
                end
                lAck: begin
                    // ack 1, 0, 1 then hold high while owned
                    arbSend <= (stepCnt != STEP_W'(1));
                    stepCnt <= stepCnt + 1'b1;
                    if (stepCnt == STEP_W'(3)) begin
                        cmdGranted <= '{go: 1'b1, rw: heldCmd.rw, wrByte: heldCmd.wrByte};
                        state      <= lOwned;
                    end
                end

                //////////////////////////////////////////////////////////////////
                // ownership and release
                //////////////////////////////////////////////////////////////////
                lOwned: begin
                    arbSend <= 1'b1;
                    if (shiftResult.done) begin
                        xferDone.rdByte <= shiftResult.rdByte;
                        arbSend         <= 1'b0;   // release starts low
                        stepCnt         <= '0;
                        state           <= lRelease;
                    end
                end
                lRelease: begin
                    arbSend <= (stepCnt != STEP_W'(2));   // 1, 1, then back to 0
                    stepCnt <= stepCnt + 1'b1;
                    if (stepCnt == STEP_W'(2)) begin
                        xferDone.done <= 1'b1;
                        state         <= lIdle;
                    end
                end
                default: state <= lIdle;
            endcase
        end
    end

    // sequencer waits for xferDone before the next command
    goOnlyWhenIdle: assert property (
        @(posedge clk) disable iff (!rstN) cmdReq.go |-> (state == lIdle)
    );

endmodule

`default_nettype wire

//--- transferSequencer.sv
`default_nettype none

module transferSequencer #(
    parameter int DATA_WIDTH  = 8,
    parameter int HOLD_CYCLES = 5
) (
    input  wire logic                       clk,
    input  wire logic                       rstN,
    input  wire logic                       start,
    input  wire logic                       eoc,
    input  wire busMasterPkg::xferResult_t  xferDone,
    output busMasterPkg::busCmd_t           cmdReq,
    output logic [DATA_WIDTH-1:0]           dataOut,
    output logic                            doneCom
);

    typedef enum logic [2:0] {
        sIdle,
        sWaitRead,
        sHold,
        sWaitWrite,
        sFinished
    } seqState_t;

    localparam int HOLD_W = $clog2(HOLD_CYCLES + 1);

    seqState_t             state;
    logic [DATA_WIDTH-1:0] workByte;   // next byte to write
    logic [HOLD_W-1:0]     holdCnt;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= sIdle;
            cmdReq   <= '0;
            workByte <= '0;
            holdCnt  <= '0;
            dataOut  <= '0;
            doneCom  <= 1'b0;
        end else begin
            cmdReq.go <= 1'b0;   // strobe
            case (state)
                sIdle: begin
                    if (eoc) begin
                        state <= sFinished;
                    end else if (start) begin
                        cmdReq <= '{go: 1'b1, rw: 1'b0, wrByte: workByte};
                        state  <= sWaitWrite;
                    end else begin
                        cmdReq <= '{go: 1'b1, rw: 1'b1, wrByte: workByte};
                        state  <= sWaitRead;
                    end
                end
                sWaitRead: begin
                    if (xferDone.done) begin
                        dataOut  <= xferDone.rdByte;
                        workByte <= xferDone.rdByte + 1'b1;   // wraps at 2^DATA_WIDTH
                        holdCnt  <= '0;
                        state    <= sHold;
                    end
                end
                sHold: begin
                    // byte stays on dataOut for HOLD_CYCLES
                    if (holdCnt == HOLD_W'(HOLD_CYCLES - 1)) begin
                        if (eoc) begin
                            state <= sFinished;
                        end else begin
                            cmdReq <= '{go: 1'b1, rw: 1'b0, wrByte: workByte};
                            state  <= sWaitWrite;
                        end
                    end else begin
                        holdCnt <= holdCnt + 1'b1;
                    end
                end
                sWaitWrite: begin
                    if (xferDone.done) begin
                        if (eoc) begin
                            state <= sFinished;
                        end else begin
                            cmdReq <= '{go: 1'b1, rw: 1'b1, wrByte: workByte};
                            state  <= sWaitRead;
                        end
                    end
                end
                sFinished: doneCom <= 1'b1;   // no more requests
                default:   state <= sIdle;
            endcase
        end
    end

    // end of communication is final until reset
    doneComSticky: assert property (
        @(posedge clk) disable iff (!rstN) doneCom |=> doneCom
    );

endmodule

`default_nettype wire

//--- busMasterPkg.sv
`default_nettype none

package busMasterPkg;

    //////////////////////////////////////////////////////////////////////
    // frame layout
    //////////////////////////////////////////////////////////////////////

    // must match the top-level DATA_WIDTH
    localparam int DATA_WIDTH = 8;

    localparam logic [2:0] START_PATTERN = 3'b111;   // opens request and control

    localparam int SLAVE_ID_W = 3;

    // request word is start pattern then slave id
    localparam int REQ_LEN = $bits(START_PATTERN) + SLAVE_ID_W;

    // control frame adds the rw bit
    localparam int CONTROL_LEN = REQ_LEN + 1;

    //////////////////////////////////////////////////////////////////////
    // stage handoff
    //////////////////////////////////////////////////////////////////////

    // one transaction request
    typedef struct packed {
        logic                  go;       // single-cycle strobe
        logic                  rw;       // 1 read, 0 write
        logic [DATA_WIDTH-1:0] wrByte;   // payload for writes
    } busCmd_t;

    // end of a transaction
    typedef struct packed {
        logic                  done;     // single-cycle strobe
        logic [DATA_WIDTH-1:0] rdByte;   // valid after a read
    } xferResult_t;

endpackage

`default_nettype wire
